// ==== design/fc_dims_pkg.sv ====
// ==========================================================================
// default sizes of the neuron, picked up by the top level as its parameters
// ==========================================================================

package fc_dims_pkg;

	// activations per input beat, one per lane
	localparam int LANES_DEF = 6;

	// beats per pass
	localparam int BEATS_DEF = 16;

	// passes per result
	// fixed, the pass state enum names exactly two
	localparam int PASSES = 2;

	// weights loaded after reset
	localparam int weight_count = PASSES * LANES_DEF * BEATS_DEF;

endpackage

// ==== design/fc_types_pkg.sv ====
// ==========================================================================
// data widths of the neuron datapath and the pass state encoding
// ==========================================================================

package fc_types_pkg;

	// one input activation
	typedef logic signed [7:0] din_t;

	// one stored weight
	typedef logic signed [7:0] weight_t;

	// one lane product, 8x8 signed
	typedef logic signed [15:0] prod_t;

	// sum of all lane products of one beat
	typedef logic signed [19:0] tree_sum_t;

	// running total over a whole result, 32 beats
	typedef logic signed [23:0] acc_t;

	// result port, sign extended from acc_t
	typedef logic signed [31:0] dout_t;

	// weight loading, then low and high half of the weight array
	typedef enum logic [1:0] {
		st_load    = 2'd0,
		st_pass_lo = 2'd1,
		st_pass_hi = 2'd2
	} pass_state_e;

endpackage

// ==== design/fc_pass_fsm.sv ====
// ==========================================================================
// pass sequencing: waits for the weights, then accepts beats and alternates
// between the low and high weight half, flagging the last beat of a result
// ==========================================================================
`timescale 1ns/1ns

module fc_pass_fsm
	import fc_types_pkg::*;
(
	input  logic clk,
	input  logic rstn,
	input  logic in_valid,  // input beat level
	input  logic loaded,    // all weights written
	input  logic pass_end,  // take of the last beat in a pass
	output logic beat_take,
	output logic pass_hi,
	output logic beat_last
);

	pass_state_e state;
	pass_state_e state_nxt;

	// next state
	always_comb
	begin
		state_nxt = state;
		case (state)
			st_load:
			begin
				if (loaded)
					state_nxt = st_pass_lo;  // loading done, start first pass
			end
			st_pass_lo:
			begin
				if (pass_end)
					state_nxt = st_pass_hi;
			end
			st_pass_hi:
			begin
				if (pass_end)
					state_nxt = st_pass_lo;  // result done, next one starts low
			end
			default: state_nxt = st_load;
		endcase
	end

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
			state <= st_load;
		else
			state <= state_nxt;
	end

	// beats offered during loading are dropped
	assign beat_take = in_valid && (state != st_load);
	assign pass_hi   = (state == st_pass_hi);  // selects upper weight half
	assign beat_last = pass_end && (state == st_pass_hi);  // 32nd beat

endmodule

// ==== design/fc_beat_counter.sv ====
// ==========================================================================
// beat index inside the current pass, wraps after BEATS accepted beats
// ==========================================================================
`timescale 1ns/1ns

module fc_beat_counter #(
	parameter int BEATS = 16
) (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic                     beat_take,
	output logic [$clog2(BEATS)-1:0] beat_idx,
	output logic                     pass_end
);

	localparam int IDX_W = $clog2(BEATS);

	logic at_top;  // counter sits on the last beat of a pass

	assign at_top = (beat_idx == IDX_W'(BEATS - 1));

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
			beat_idx <= '0;
		else if (beat_take)
		begin
			if (at_top)
				beat_idx <= '0;  // wrap, next pass starts at beat 0
			else
				beat_idx <= beat_idx + 1'b1;
		end
	end

	// only on an actual take, idle cycles at the top count do not end a pass
	assign pass_end = beat_take && at_top;

endmodule

// ==== design/fc_weight_store.sv ====
// ==========================================================================
// weight array loaded serially after reset; hands one weight per lane to
// the multipliers, addressed by the current pass and beat
// ==========================================================================
`timescale 1ns/1ns

module fc_weight_store
	import fc_dims_pkg::*;
	import fc_types_pkg::*;
#(
	parameter int LANES = 6,
	parameter int BEATS = 16
) (
	input  logic                     clk,
	input  logic                     rstn,
	input  weight_t                  weight,     // serial weight input
	input  logic                     weight_en,  // one write per high cycle
	input  logic                     pass_hi,
	input  logic [$clog2(BEATS)-1:0] beat_idx,
	output logic                     loaded,
	output weight_t                  lane_w [LANES]
);

	localparam int PASS_SIZE = LANES * BEATS;      // weights used by one pass
	localparam int WEIGHTS   = PASSES * PASS_SIZE;
	localparam int PTR_W     = $clog2(WEIGHTS + 1);  // must hold WEIGHTS itself

	weight_t            mem [WEIGHTS];
	logic [PTR_W-1:0]   wr_ptr;

	// pointer saturates at WEIGHTS
	assign loaded = (wr_ptr == PTR_W'(WEIGHTS));  // one cycle after the last write

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
			wr_ptr <= '0;
		else if (weight_en && !loaded)
			wr_ptr <= wr_ptr + 1'b1;
	end

	// write port, one weight per strobe
	always_ff @(posedge clk)
	begin
		if (weight_en && !loaded)
			mem[wr_ptr] <= weight;  // late weight_en strobes are ignored
	end

	// read side
	// lane l, beat k of pass p reads p*LANES*BEATS + l*BEATS + k
	always_comb
	begin
		for (int l = 0; l < LANES; l++)
		begin
			lane_w[l] = mem[(pass_hi ? PASS_SIZE : 0) + l * BEATS + int'(beat_idx)];
		end
	end

endmodule

// ==== design/fc_mac_tree.sv ====
// ==========================================================================
// lane multipliers followed by a registered pairwise adder tree; valid and
// last tags travel beside the data with the same latency
// ==========================================================================
`timescale 1ns/1ns

module fc_mac_tree
	import fc_types_pkg::*;
#(
	parameter int LANES = 6
) (
	input  logic      clk,
	input  logic      rstn,
	input  logic      beat_take,     // beat accepted this cycle
	input  logic      beat_last,     // ... and it closes a result
	input  din_t      din [LANES],
	input  weight_t   lane_w [LANES],
	output logic      sum_valid,
	output logic      sum_last,
	output tree_sum_t sum
);

	localparam int LEVELS = $clog2(LANES);  // adder levels after the products
	localparam int NODES  = 1 << LEVELS;    // widest level, rounded up

	prod_t     prod [LANES];
	tree_sum_t node [LEVELS+1][NODES];  // node[0] holds the registered products
	logic [LEVELS:0] vld_sr;
	logic [LEVELS:0] last_sr;

	// signed 8x8 product fits 16 bits
	always_comb
	begin
		for (int i = 0; i < LANES; i++)
		begin
			prod[i] = din[i] * lane_w[i];
		end
	end

	generate
		for (genvar i = 0; i < LANES; i++)
		begin : g_prod
			always_ff @(posedge clk or negedge rstn)
			begin
				if (!rstn)
					node[0][i] <= '0;
				else
					node[0][i] <= tree_sum_t'(prod[i]);  // sign extended
			end
		end

		// a node exists while its subtree covers at least one lane
		for (genvar lv = 1; lv <= LEVELS; lv++)
		begin : g_level
			for (genvar i = 0; i * (1 << lv) < LANES; i++)
			begin : g_add
				if ((2 * i + 1) * (1 << (lv - 1)) < LANES)
				begin : g_pair
					always_ff @(posedge clk or negedge rstn)
					begin
						if (!rstn)
							node[lv][i] <= '0;
						else
							node[lv][i] <= node[lv-1][2*i] + node[lv-1][2*i+1];
					end
				end
				else
				begin : g_single
					always_ff @(posedge clk or negedge rstn)
					begin
						if (!rstn)
							node[lv][i] <= '0;
						else
							node[lv][i] <= node[lv-1][2*i];  // odd node passes through
					end
				end
			end
		end
	endgenerate

	// tag pipeline with one stage per data register
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			vld_sr  <= '0;
			last_sr <= '0;
		end
		else
		begin
			vld_sr[0]  <= beat_take;
			last_sr[0] <= beat_take && beat_last;
			for (int s = 1; s <= LEVELS; s++)
			begin
				vld_sr[s]  <= vld_sr[s-1];
				last_sr[s] <= last_sr[s-1];
			end
		end
	end

	assign sum       = node[LEVELS][0];  // tree root
	assign sum_valid = vld_sr[LEVELS];
	assign sum_last  = last_sr[LEVELS];

endmodule

// ==== design/fc_accumulator.sv ====
// ==========================================================================
// adds each beat sum to the running total; on the last beat of a result
// the total goes out with a one-cycle strobe and the total restarts at zero
// ==========================================================================
`timescale 1ns/1ns

module fc_accumulator
	import fc_types_pkg::*;
(
	input  logic      clk,
	input  logic      rstn,
	input  logic      sum_valid,
	input  logic      sum_last,
	input  tree_sum_t sum,
	output logic      out_valid,
	output dout_t     dout
);

	acc_t acc;
	acc_t acc_nxt;  // total including the incoming sum

	assign acc_nxt = acc + acc_t'(sum);

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			acc       <= '0;
			dout      <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= sum_valid && sum_last;  // one cycle strobe
			if (sum_valid)
			begin
				if (sum_last)
				begin
					dout <= dout_t'(acc_nxt);  // held until the next result
					acc  <= '0;                // next result starts clean
				end
				else
					acc <= acc_nxt;
			end
		end
	end

endmodule

// ==== design/fc_neuron.sv ====
// ==========================================================================
// fully connected neuron: serial weight load, then 32 six-lane beats per
// result; dout is valid with the out_valid strobe
// ==========================================================================
`timescale 1ns/1ns

module fc_neuron
	import fc_dims_pkg::*;
	import fc_types_pkg::*;
#(
	parameter int LANES = LANES_DEF,
	parameter int BEATS = BEATS_DEF
) (
	input  logic    clk,
	input  logic    rstn,
	input  weight_t weight,
	input  logic    weight_en,     // write strobe for weight
	input  logic    in_valid,      // level, one beat per high cycle
	input  din_t    din [LANES],
	output logic    out_valid,
	output dout_t   dout
);

	localparam int IDX_W = $clog2(BEATS);

	logic             loaded;
	logic             beat_take;
	logic             pass_hi;
	logic             pass_end;
	logic             beat_last;
	logic [IDX_W-1:0] beat_idx;
	weight_t          lane_w [LANES];
	logic             sum_valid;
	logic             sum_last;
	tree_sum_t        sum;

	fc_pass_fsm i_pass_fsm (
		.clk       (clk),
		.rstn      (rstn),
		.in_valid  (in_valid),
		.loaded    (loaded),
		.pass_end  (pass_end),
		.beat_take (beat_take),
		.pass_hi   (pass_hi),
		.beat_last (beat_last)
	);

	fc_beat_counter #(
		.BEATS (BEATS)
	) i_beat_counter (
		.clk       (clk),
		.rstn      (rstn),
		.beat_take (beat_take),
		.beat_idx  (beat_idx),
		.pass_end  (pass_end)
	);

	fc_weight_store #(
		.LANES (LANES),
		.BEATS (BEATS)
	) i_weight_store (
		.clk       (clk),
		.rstn      (rstn),
		.weight    (weight),
		.weight_en (weight_en),
		.pass_hi   (pass_hi),
		.beat_idx  (beat_idx),
		.loaded    (loaded),
		.lane_w    (lane_w)
	);

	// products plus tree, 4 cycles for six lanes
	fc_mac_tree #(
		.LANES (LANES)
	) i_mac_tree (
		.clk       (clk),
		.rstn      (rstn),
		.beat_take (beat_take),
		.beat_last (beat_last),
		.din       (din),
		.lane_w    (lane_w),
		.sum_valid (sum_valid),
		.sum_last  (sum_last),
		.sum       (sum)
	);

	fc_accumulator i_accumulator (
		.clk       (clk),
		.rstn      (rstn),
		.sum_valid (sum_valid),
		.sum_last  (sum_last),
		.sum       (sum),
		.out_valid (out_valid),
		.dout      (dout)
	);

endmodule

// ==== sim/tb_clock_gen.sv ====
// ==========================================================================
// testbench clock, 20 ns period, and active low reset held for four cycles
// ==========================================================================
`timescale 1ns/1ns

module tb_clock_gen (
	input  logic rst_req,  // rising edge starts another reset
	output logic clk,
	output logic rstn
);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		rstn = 1'b0;  // power-on reset
		repeat (4) @(posedge clk);
		rstn <= 1'b1;
		forever
		begin
			@(posedge rst_req);
			rstn <= 1'b0;
			repeat (4) @(posedge clk);  // same length as the first one
			rstn <= 1'b1;
		end
	end

endmodule

// ==== sim/tb_fc_neuron.sv ====
// ==========================================================================
// neuron testbench: random weight loads and beats, results checked against
// a dot-product model in order, plus the out_valid latency
// ==========================================================================
`timescale 1ns/1ns

module tb_fc_neuron
	import fc_dims_pkg::*;
	import fc_types_pkg::*;
;

	localparam int N_BEATS     = PASSES * BEATS_DEF;  // beats per result
	localparam int N_RESULTS   = 11;
	localparam int MAX_GAP     = 3;                   // idle cycles between beats
	localparam int OUT_LAT     = 5;                   // take cycle of last beat to out_valid
	localparam int LATE_WRITES = 8;
	localparam int LOAD_CYC    = 2 * (4 + weight_count + 4) + LATE_WRITES;
	localparam int BEAT_CYC    = N_RESULTS * N_BEATS;
	localparam int GAP_CYC     = 9 * (N_BEATS + 1) * MAX_GAP + N_RESULTS * (OUT_LAT + 4);
	localparam int TIMEOUT     = 2 * (LOAD_CYC + BEAT_CYC + GAP_CYC);

	logic    clk;
	logic    rstn;
	logic    rst_req;
	weight_t weight;
	logic    weight_en;
	logic    in_valid;
	din_t    din [LANES_DEF];
	logic    out_valid;
	dout_t   dout;

	integer  seed;
	int      cyc;        // posedges seen so far
	int      n_checked;
	logic    in_load;    // weights being written
	weight_t w_model [weight_count];
	din_t    act [N_BEATS][LANES_DEF];  // beats of the current result
	dout_t   exp_q [$];
	int      last_q [$];   // edge that puts each 32nd beat on din
	dout_t   last_dout;

	tb_clock_gen i_clock_gen (
		.rst_req (rst_req),
		.clk     (clk),
		.rstn    (rstn)
	);

	fc_neuron #(
		.LANES (LANES_DEF),
		.BEATS (BEATS_DEF)
	) i_fc_neuron (
		.clk       (clk),
		.rstn      (rstn),
		.weight    (weight),
		.weight_en (weight_en),
		.in_valid  (in_valid),
		.din       (din),
		.out_valid (out_valid),
		.dout      (dout)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_dout(input dout_t got, input dout_t exp);
		if (got !== exp)
			abort_run($sformatf("Fail dout: got 0x%h expected 0x%h", got, exp));
	endtask

	task automatic check_valid_gap(input int gap);
		if (gap != OUT_LAT)
			abort_run($sformatf("Fail out_valid: gap 0x%h expected 0x%h", gap, OUT_LAT));
	endtask

	function automatic logic [7:0] rand_byte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// dot product over both passes at index p*96 + l*16 + k
	function automatic dout_t ref_neuron();
		int total;
		total = 0;
		for (int p = 0; p < PASSES; p++)
		begin
			for (int l = 0; l < LANES_DEF; l++)
			begin
				for (int k = 0; k < BEATS_DEF; k++)
				begin
					total += int'(w_model[p * LANES_DEF * BEATS_DEF + l * BEATS_DEF + k])
						* int'(act[p * BEATS_DEF + k][l]);
				end
			end
		end
		return total;
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			weight_en <= 1'b0;
			in_valid  <= 1'b0;
		end
	endtask

	// full serial load with beats optionally offered throughout
	task automatic load_weights(input bit all_min, input bit valid_during_load);
		in_load = 1'b1;
		for (int i = 0; i < weight_count; i++)
		begin
			@(posedge clk);
			w_model[i] = all_min ? 8'h80 : rand_byte();
			weight    <= w_model[i];
			weight_en <= 1'b1;
			in_valid  <= valid_during_load;
			for (int l = 0; l < LANES_DEF; l++)
				din[l] <= rand_byte();
		end
		idle_cycles(4);  // FSM leaves st_load in here
		in_load = 1'b0;
	endtask

	// strobes past the end of the array leave the model as loaded
	task automatic write_late_weights(input int n);
		repeat (n)
		begin
			@(posedge clk);
			weight    <= rand_byte();
			weight_en <= 1'b1;
		end
		idle_cycles(1);
	endtask

	task automatic drive_result(input int max_gap, input bit all_min);
		int gap;
		for (int b = 0; b < N_BEATS; b++)
			for (int l = 0; l < LANES_DEF; l++)
				act[b][l] = all_min ? 8'h80 : rand_byte();
		exp_q.push_back(ref_neuron());
		for (int b = 0; b < N_BEATS; b++)
		begin
			gap = (b == 0 || max_gap == 0) ? 0 : int'(rand_byte()) % (max_gap + 1);
			idle_cycles(gap);
			@(posedge clk);
			in_valid <= 1'b1;
			for (int l = 0; l < LANES_DEF; l++)
				din[l] <= act[b][l];
			if (b == N_BEATS - 1)
				last_q.push_back(cyc + 1);  // edge driving the 32nd beat
		end
	endtask

	task automatic wait_results();
		while (exp_q.size() != 0)
			@(posedge clk);
		@(posedge clk);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_req <= 1'b1;
		wait (rstn === 1'b0);
		@(posedge clk);
		rst_req <= 1'b0;
		wait (rstn === 1'b1);
	endtask

	// cycle count and run limit
	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		if (cyc > TIMEOUT)
			abort_run($sformatf("run did not finish within %0d cycles", TIMEOUT));
	end

	// compare on the falling edge with outputs settled
	always @(negedge clk)
	begin
		if (!rstn)
			last_dout = '0;
		else if (out_valid === 1'b1)
		begin
			if (in_load)
				abort_run("out_valid pulsed while weights were loading");
			else if (exp_q.size() == 0)
				abort_run("out_valid pulsed with no result outstanding");
			else
			begin
				last_dout = exp_q.pop_front();
				check_dout(dout, last_dout);
				check_valid_gap(cyc - last_q.pop_front());
				n_checked++;
			end
		end
		else
			check_dout(dout, last_dout);  // held between results and 0 after reset
	end

	initial
	begin
		seed      = 72715;
		cyc       = 0;
		n_checked = 0;
		in_load   = 1'b0;
		rst_req   = 1'b0;
		weight    = '0;
		weight_en = 1'b0;
		in_valid  = 1'b0;
		for (int l = 0; l < LANES_DEF; l++)
			din[l] = '0;
		wait (rstn === 1'b1);

		load_weights(1'b0, 1'b1);  // beats offered during load
		drive_result(0, 1'b0);     // back to back beats
		idle_cycles(1);
		wait_results();

		write_late_weights(LATE_WRITES);
		drive_result(MAX_GAP, 1'b0);
		idle_cycles(1);
		wait_results();

		// eight results with 3 and 4 back to back
		for (int r = 0; r < 8; r++)
		begin
			drive_result(MAX_GAP, 1'b0);
			if (r != 3)
				idle_cycles(int'(rand_byte()) % MAX_GAP + 1);
		end
		idle_cycles(1);
		wait_results();

		// largest positive total
		apply_reset();
		load_weights(1'b1, 1'b0);
		drive_result(0, 1'b1);
		idle_cycles(1);
		wait_results();
		idle_cycles(4);

		if (n_checked == N_RESULTS)
		begin
			$display("All tests passed!");
			$finish;
		end
		else
			abort_run($sformatf("only %0d of %0d results seen", n_checked, N_RESULTS));
	end

endmodule

// ==== project.f ====
design/fc_dims_pkg.sv
design/fc_types_pkg.sv
design/fc_pass_fsm.sv
design/fc_beat_counter.sv
design/fc_weight_store.sv
design/fc_mac_tree.sv
design/fc_accumulator.sv
design/fc_neuron.sv
sim/tb_clock_gen.sv
sim/tb_fc_neuron.sv

// ==== Bender.yml ====
package:
  name: fc_neuron

sources:
  # RTL, packages first
  - files:
      - design/fc_dims_pkg.sv
      - design/fc_types_pkg.sv
      - design/fc_pass_fsm.sv
      - design/fc_beat_counter.sv
      - design/fc_weight_store.sv
      - design/fc_mac_tree.sv
      - design/fc_accumulator.sv
      - design/fc_neuron.sv

  # testbench, top module tb_fc_neuron
  - target: test
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_fc_neuron.sv
